//--- all.f
+incdir+.
fifo_pkg.sv
ram_vector.sv
pointers.sv
fifo_vector.sv
dot_sequencer.sv
dot_product_top.sv
dot_product_assertions.sv
dot_product_tb.sv

//--- Bender.yml
package:
  name: dot_product

sources:
  - include_dirs:
      - .
    files:
      - fifo_pkg.sv
      - ram_vector.sv
      - pointers.sv
      - fifo_vector.sv
      - dot_sequencer.sv
      - dot_product_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dot_product_assertions.sv
      - dot_product_tb.sv

//--- dot_product_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dot_product_tb;

	localparam int A_FIRST     = 0;
	localparam int B_FIRST     = 1;
	localparam int INTERLEAVED = 2;
	localparam int TIMEOUT     = 100;
	localparam int QUIET       = 60;
	localparam int NUM_CASES   = 17;

	typedef struct {
		int n;
		bit rnd;
		int ea;
		int eb;
		int pattern;
		bit overlap;
		bit short_b;
		bit reset_mid;
	} case_t;

	// n, random, fixed a, fixed b, push order, overlap, b one short, reset mid-stream
	case_t cases [NUM_CASES] = '{
		'{1, 1, 0, 0, A_FIRST, 0, 0, 0},
		'{15, 0, 255, 255, INTERLEAVED, 0, 0, 0},
		'{1, 0, 255, 255, B_FIRST, 0, 0, 0},
		'{5, 1, 0, 0, B_FIRST, 0, 0, 0},
		'{7, 1, 0, 0, INTERLEAVED, 0, 1, 0},
		'{4, 1, 0, 0, INTERLEAVED, 1, 0, 0},
		'{6, 1, 0, 0, A_FIRST, 0, 0, 1},
		'{8, 1, 0, 0, INTERLEAVED, 1, 0, 0},
		'{15, 1, 0, 0, A_FIRST, 0, 0, 0},
		'{11, 1, 0, 0, INTERLEAVED, 0, 0, 0},
		'{3, 1, 0, 0, B_FIRST, 0, 0, 0},
		'{13, 1, 0, 0, A_FIRST, 0, 1, 0},
		'{2, 1, 0, 0, A_FIRST, 0, 0, 0},
		'{9, 1, 0, 0, B_FIRST, 0, 0, 1},
		'{10, 1, 0, 0, INTERLEAVED, 0, 0, 0},
		'{12, 1, 0, 0, A_FIRST, 0, 0, 0},
		'{14, 1, 0, 0, B_FIRST, 0, 0, 0}
	};

	logic              clk;
	logic              reset;
	logic              push_a;
	logic              push_b;
	fifo_pkg::data_t   data_a;
	fifo_pkg::data_t   data_b;
	fifo_pkg::nibble_t n;
	fifo_pkg::acc_t    result;
	logic              result_valid;
	logic              busy;

	// up to two vector pairs in flight
	fifo_pkg::data_t va [2][15];
	fifo_pkg::data_t vb [2][15];
	logic [31:0] rng = 32'd39227;
	// sums seen on result_valid in arrival order
	fifo_pkg::acc_t results [$];
	int busy_run;
	logic valid_prev;

	dot_product_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.push_a       (push_a),
		.push_b       (push_b),
		.data_a       (data_a),
		.data_b       (data_b),
		.n            (n),
		.result       (result),
		.result_valid (result_valid),
		.busy         (busy)
	);

	bind fifo_vector dot_product_assertions chk (.clk(clk), .reset(reset), .wr_en(wr_en),
		.rd_en(rd_en), .pop(1'b0), .busy(1'b0), .result_valid(1'b0));
	bind dot_sequencer dot_product_assertions chk (.clk(clk), .reset(reset), .wr_en(1'b0),
		.rd_en(1'b0), .pop(pop), .busy(busy), .result_valid(result_valid));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// failed assertions over all bound checkers
	function automatic int assertion_errors();
		return dut_i.fifo_a.chk.errors + dut_i.fifo_b.chk.errors + dut_i.seq.chk.errors;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ==================================================
	// output monitor sampled mid-cycle
	// ==================================================
	always @(negedge clk) begin
		if (assertion_errors() != 0) begin
			$display("an assertion failed inside the DUT");
			$display("Verification failed");
			$fatal(1, "assertion failure");
		end else if (reset) begin
			busy_run = 0;
			valid_prev = 1'b0;
		end else begin
			// busy must drop right after the pulse
			if (valid_prev)
				check("busy", busy, 0);
			if (busy)
				busy_run = busy_run + 1;
			else
				busy_run = 0;
			if (result_valid) begin
				check("busy", busy, 1);
				// busy covers n+3 cycles up to the pulse
				check("busy_cycles", busy_run, int'(n) + 3);
				results.push_back(result);
			end
			valid_prev = result_valid;
		end
	end

	task automatic drive(input logic pa, input logic pb, input fifo_pkg::data_t da,
		input fifo_pkg::data_t db);
		@(negedge clk);
		push_a = pa;
		push_b = pb;
		data_a = da;
		data_b = db;
	endtask

	// pushes a[lo..hi_a-1] and b[lo..hi_b-1] of pair p in the given order
	task automatic push_vectors(input int p, input int pattern, input int lo, input int hi_a,
		input int hi_b);
		int i;
		if (pattern == INTERLEAVED) begin
			for (i = lo; i < hi_a || i < hi_b; i++)
				drive(i < hi_a, i < hi_b, va[p][i], vb[p][i]);
		end else if (pattern == A_FIRST) begin
			for (i = lo; i < hi_a; i++)
				drive(1'b1, 1'b0, va[p][i], '0);
			for (i = lo; i < hi_b; i++)
				drive(1'b0, 1'b1, '0, vb[p][i]);
		end else begin
			for (i = lo; i < hi_b; i++)
				drive(1'b0, 1'b1, '0, vb[p][i]);
			for (i = lo; i < hi_a; i++)
				drive(1'b1, 1'b0, va[p][i], '0);
		end
		drive(1'b0, 1'b0, '0, '0);
	endtask

	task automatic make_vectors(input int p, input int c);
		int i;
		for (i = 0; i < 15; i++) begin
			if (cases[c].rnd) begin
				rng = xorshift(rng);
				va[p][i] = rng[7:0];
				rng = xorshift(rng);
				vb[p][i] = rng[15:8];
			end else begin
				va[p][i] = fifo_pkg::data_t'(cases[c].ea);
				vb[p][i] = fifo_pkg::data_t'(cases[c].eb);
			end
		end
	endtask

	// sum of a[i]*b[i] over the first len elements
	function automatic int dot_sum(input int p, input int len);
		int i;
		int sum;
		sum = 0;
		for (i = 0; i < len; i++)
			sum += int'(va[p][i]) * int'(vb[p][i]);
		return sum;
	endfunction

	task automatic wait_result(input int expected);
		int t;
		t = 0;
		while (results.size() == 0 && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (results.size() == 0) begin
			$display("timed out waiting for result_valid");
			$display("Verification failed");
			$fatal(1, "no result");
		end else begin
			check("result", results.pop_front(), expected);
		end
	endtask

	// no result may show up in this window
	task automatic expect_quiet();
		int t;
		for (t = 0; t < QUIET; t++)
			@(negedge clk);
		check("result_count", results.size(), 0);
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		int c;
		int p;
		int len;
		int expected [2];
		reset = 1'b1;
		push_a = 1'b0;
		push_b = 1'b0;
		data_a = '0;
		data_b = '0;
		n = 4'd1;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		for (c = 0; c < NUM_CASES; c++) begin
			len = cases[c].n;
			@(negedge clk);
			n = fifo_pkg::nibble_t'(len);
			for (p = 0; p < 2; p++) begin
				make_vectors(p, c);
				expected[p] = dot_sum(p, len);
			end
			// reset lands just after the start and throws the pair away
			if (cases[c].reset_mid) begin
				push_vectors(0, cases[c].pattern, 0, len, len);
				@(negedge clk);
				reset = 1'b1;
				repeat (2) @(negedge clk);
				reset = 1'b0;
				expect_quiet();
			end
			if (cases[c].short_b) begin
				// nothing may start while b is one short
				push_vectors(0, cases[c].pattern, 0, len, len - 1);
				expect_quiet();
				push_vectors(0, cases[c].pattern, len - 1, len - 1, len);
			end else begin
				push_vectors(0, cases[c].pattern, 0, len, len);
			end
			// second pair queued behind the first
			if (cases[c].overlap)
				push_vectors(1, cases[c].pattern, 0, len, len);
			wait_result(expected[0]);
			if (cases[c].overlap)
				wait_result(expected[1]);
		end

		// let the monitor see busy drop after the last pulse
		repeat (2) @(negedge clk);

		if (assertion_errors() != 0) begin
			$display("assertion failures reported in the DUT");
			$display("Verification failed");
			$fatal(1, "assertion failures");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- dot_product_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "dot_params.svh"

module dot_product_assertions (
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire rd_en,
	input wire pop,
	input wire busy,
	input wire result_valid
);

	// occupancy rebuilt from the gated strobes
	logic [`COUNT_N:0] occ;
	// failed assertions so far
	int errors = 0;

	always_ff @(posedge clk) begin
		if (reset)
			occ <= '0;
		else if (wr_en && !rd_en)
			occ <= occ + 1'b1;
		else if (rd_en && !wr_en)
			occ <= occ - 1'b1;
	end

	// ==================================================
	// fifo side
	// ==================================================
	no_empty_pop: assert property (@(posedge clk) disable iff (reset) rd_en |-> occ != '0)
		else begin
			$error("rd_en high on an empty fifo");
			errors++;
		end

	// ==================================================
	// sequencer side
	// ==================================================
	valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
		result_valid |=> !result_valid)
		else begin
			$error("result_valid longer than one cycle");
			errors++;
		end

	valid_while_busy: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> busy)
		else begin
			$error("result_valid while not busy");
			errors++;
		end

	// pop only inside a computation
	pop_while_busy: assert property (@(posedge clk) disable iff (reset) pop |-> busy)
		else begin
			$error("pop while not busy");
			errors++;
		end

endmodule

`default_nettype wire

//--- dot_product_top.sv
`timescale 1ns/100ps
`default_nettype none

module dot_product_top (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 push_a,
	input  wire                 push_b,
	input  fifo_pkg::data_t     data_a,
	input  fifo_pkg::data_t     data_b,
	input  fifo_pkg::nibble_t   n,
	output fifo_pkg::acc_t      result,
	output logic                result_valid,
	output logic                busy
);

	// common pop to both fifos
	logic            pop;
	logic            ready_a;
	logic            ready_b;
	fifo_pkg::data_t elem_a;
	fifo_pkg::data_t elem_b;

	// ==================================================
	// vector a and vector b fifos
	// ==================================================
	fifo_vector fifo_a (
		.clk      (clk),
		.reset    (reset),
		.push     (push_a),
		.pop      (pop),
		.data_in  (data_a),
		.n        (n),
		.data_out (elem_a),
		.ready    (ready_a)
	);

	fifo_vector fifo_b (
		.clk      (clk),
		.reset    (reset),
		.push     (push_b),
		.pop      (pop),
		.data_in  (data_b),
		.n        (n),
		.data_out (elem_b),
		.ready    (ready_b)
	);

	// pops both in lockstep, accumulates the products
	dot_sequencer seq (
		.clk          (clk),
		.reset        (reset),
		.n            (n),
		.ready_a      (ready_a),
		.ready_b      (ready_b),
		.elem_a       (elem_a),
		.elem_b       (elem_b),
		.pop          (pop),
		.result       (result),
		.result_valid (result_valid),
		.busy         (busy)
	);

endmodule

`default_nettype wire

//--- dot_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module dot_sequencer (
	input  wire                 clk,
	input  wire                 reset,
	input  fifo_pkg::nibble_t   n,
	input  wire                 ready_a,
	input  wire                 ready_b,
	input  fifo_pkg::data_t     elem_a,
	input  fifo_pkg::data_t     elem_b,
	output logic                pop,
	output fifo_pkg::acc_t      result,
	output logic                result_valid,
	output logic                busy
);

	// pops still to issue, loaded from n at start
	fifo_pkg::nibble_t cnt;
	// pop delayed once: elem_a / elem_b hold a valid pair
	logic pop_d;
	// pop delayed twice: marks the cycle after each accumulation
	logic pop_dd;
	logic start;
	logic last;
	fifo_pkg::acc_t acc;
	fifo_pkg::acc_t product;

	// idle and both vectors complete
	assign start = ~busy & ready_a & ready_b;

	// last accumulation has just landed
	assign last = pop_dd & ~pop_d;

	// 8x8 product, widened before the multiply
	assign product = fifo_pkg::acc_t'(elem_a) * fifo_pkg::acc_t'(elem_b);

	// ==================================================
	// control: start, pop count, busy
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			pop  <= 1'b0;
			cnt  <= '0;
		end else begin
			if (start) begin
				// latch n, pop for the next n cycles
				busy <= 1'b1;
				pop  <= 1'b1;
				cnt  <= n;
			end else if (pop) begin
				cnt <= cnt - 1'b1;
				if (cnt == 4'd1)
					pop <= 1'b0;
			end
			// busy drops after the result_valid cycle
			if (result_valid)
				busy <= 1'b0;
		end
	end

	// pop delay line and result strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			pop_d        <= 1'b0;
			pop_dd       <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			pop_d        <= pop;
			pop_dd       <= pop_d;
			// single pulse, n+2 cycles after start
			result_valid <= last;
		end
	end

	// ==================================================
	// datapath: multiply-accumulate and result
	// ==================================================
	always_ff @(posedge clk) begin
		if (start)
			acc <= '0;
		else if (pop_d)
			acc <= acc + product;
	end

	// result holds the last sum until the next one
	always_ff @(posedge clk) begin
		if (reset)
			result <= '0;
		else if (last)
			result <= acc;
	end

endmodule

`default_nettype wire

//--- fifo_vector.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_vector (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 push,
	input  wire                 pop,
	input  fifo_pkg::data_t     data_in,
	input  fifo_pkg::nibble_t   n,
	output fifo_pkg::data_t     data_out,
	output logic                ready
);

	// gated strobes and addresses from the pointer block
	logic               wr_en;
	logic               rd_en;
	fifo_pkg::address_t wr_ptr;
	fifo_pkg::address_t rd_ptr;

	// ==================================================
	// storage
	// ==================================================
	ram_vector ram_v (
		.clk      (clk),
		.wr_en    (wr_en),
		.rd_en    (rd_en),
		.wr_ptr   (wr_ptr),
		.rd_ptr   (rd_ptr),
		.data_in  (data_in),
		.data_out (data_out)
	);

	// ==================================================
	// pointers, occupancy and ready
	// ==================================================
	pointers pointers_inst (
		.clk    (clk),
		.reset  (reset),
		.push   (push),
		.pop    (pop),
		.n      (n),
		.wr_en  (wr_en),
		.rd_en  (rd_en),
		.wr_ptr (wr_ptr),
		.rd_ptr (rd_ptr),
		.ready  (ready)
	);

endmodule

`default_nettype wire

//--- pointers.sv
`timescale 1ns/100ps
`default_nettype none

`include "dot_params.svh"

module pointers (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 push,
	input  wire                 pop,
	input  fifo_pkg::nibble_t   n,
	output logic                wr_en,
	output logic                rd_en,
	output fifo_pkg::address_t  wr_ptr,
	output fifo_pkg::address_t  rd_ptr,
	output logic                ready
);

	// occupancy, 0 up to FIFO_DEPTH
	logic [`COUNT_N:0] count;
	logic full;
	logic empty;

	// ==================================================
	// overflow / underflow gating
	// ==================================================
	assign full  = (count == (`COUNT_N+1)'(`FIFO_DEPTH));
	assign empty = (count == '0);

	// push into a full fifo is dropped
	assign wr_en = push & ~full;
	// pop from an empty fifo is ignored
	assign rd_en = pop & ~empty;

	// ==================================================
	// pointers and occupancy
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// write pointer, wraps at the last entry
			if (wr_en) begin
				if (wr_ptr == fifo_pkg::address_t'(`FIFO_DEPTH-1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			// read pointer, same wrap
			if (rd_en) begin
				if (rd_ptr == fifo_pkg::address_t'(`FIFO_DEPTH-1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// push only, pop only; both at once leaves it alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// whole vector of length n stored
	// n of zero never reports ready
	assign ready = (count >= {1'b0, n}) && (n != '0);

endmodule

`default_nettype wire

//--- ram_vector.sv
`timescale 1ns/100ps
`default_nettype none

`include "dot_params.svh"

module ram_vector (
	input  wire                 clk,
	input  wire                 wr_en,
	input  wire                 rd_en,
	input  fifo_pkg::address_t  wr_ptr,
	input  fifo_pkg::address_t  rd_ptr,
	input  fifo_pkg::data_t     data_in,
	output fifo_pkg::data_t     data_out
);

	// storage array, one element per entry
	fifo_pkg::data_t mem [`FIFO_DEPTH];

	// write port
	// wr_en is already gated by not-full
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// registered read port
	// element shows up one cycle after the pop
	// holds its value between pops
	always_ff @(posedge clk) begin
		if (rd_en) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

//--- fifo_pkg.sv
`default_nettype none

`include "dot_params.svh"

// ==================================================
// shared types of the dot-product engine
// ==================================================
package fifo_pkg;

	// one vector element
	typedef logic [`DATA_W-1:0] data_t;

	// vector length n, 1 to 15
	typedef logic [3:0] nibble_t;

	// ram address / fifo pointer
	typedef logic [`COUNT_N-1:0] address_t;

	// running and final dot product
	typedef logic [`ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

//--- dot_params.svh
`ifndef DOT_PARAMS_SVH
`define DOT_PARAMS_SVH

// ==================================================
// widths and sizes shared by the dot-product engine
// ==================================================

// one vector element
`define DATA_W 8

// entries per vector fifo
`define FIFO_DEPTH 16

// pointer width, log2 of the depth
// occupancy count is one bit wider
`define COUNT_N 4

// sum of 15 products of 255 x 255 fits in 20 bits
`define ACC_W 20

`endif
